/* verilog/rvmini_pkg.sv */
/*
  Shared constants for the RV32 subset core.
  Only LUI, ADDI, ADD and BNE are decoded; everything else is illegal.
  BOOT_ADDR must stay word aligned.
*/
package rvmini_pkg;

  // Datapath and address width
  localparam int unsigned XLEN       = 32;
  // Register index width for 32 architectural registers
  localparam int unsigned REG_ADDR_W = 5;
  // Width of the retirement logger counters
  localparam int unsigned CNT_W      = 32;

  // First fetch address after reset
  localparam logic [XLEN-1:0] BOOT_ADDR = 32'h0000_0080;

  // Major opcodes, bits [6:0] of the instruction word
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  // funct3 values
  localparam logic [2:0] F3_ADD_ADDI = 3'b000;
  localparam logic [2:0] F3_BNE      = 3'b001;

  // funct7 for ADD (SUB would set bit 5)
  localparam logic [6:0] F7_ADD = 7'b0000000;

endpackage

/* verilog/rvmini_fetch.sv */
/*
  Instruction fetch with one outstanding request on the req/gnt/rvalid bus.
  The request and address stay stable until granted, even if fetch enable drops.
  A new request rises exactly one cycle after the matching rvalid.
*/
`timescale 1ns/1ps

module rvmini_fetch import rvmini_pkg::*; (
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  logic            fetch_enable_i,

  // Instruction bus
  output logic            instr_req_o,
  output logic [XLEN-1:0] instr_addr_o,
  input  logic            instr_gnt_i,
  input  logic            instr_rvalid_i,
  input  logic [XLEN-1:0] instr_rdata_i,

  // Redirect from the execute unit
  input  logic [XLEN-1:0] next_pc_i,

  // Fetched instruction towards execute
  output logic            instr_valid_o,
  output logic [XLEN-1:0] instr_word_o,
  output logic [XLEN-1:0] instr_pc_o,
  output logic            busy_o
);

  typedef enum logic {
    FETCH_IDLE,
    FETCH_WAIT
  } fetch_state_e;

  fetch_state_e    state_q;
  logic            req_q;
  logic [XLEN-1:0] pc_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= FETCH_IDLE;
      req_q   <= 1'b0;
      pc_q    <= BOOT_ADDR;
    end else begin
      case (state_q)
        FETCH_IDLE: begin
          if (req_q) begin
            // The grant accepts the request and the address becomes outstanding
            if (instr_gnt_i) begin
              req_q   <= 1'b0;
              state_q <= FETCH_WAIT;
            end
          end else if (fetch_enable_i) begin
            req_q <= 1'b1;
          end
        end
        FETCH_WAIT: begin
          if (instr_rvalid_i) begin
            state_q <= FETCH_IDLE;
            pc_q    <= next_pc_i;
            // Back-to-back fetch one cycle after the response
            req_q   <= fetch_enable_i;
          end
        end
        default: state_q <= FETCH_IDLE;
      endcase
    end
  end

  assign instr_req_o  = req_q;
  assign instr_addr_o = pc_q;

  // pc_q only moves on rvalid, so it still names the accepted fetch here
  assign instr_valid_o = (state_q == FETCH_WAIT) && instr_rvalid_i;
  assign instr_word_o  = instr_rdata_i;
  assign instr_pc_o    = pc_q;

  assign busy_o = req_q || (state_q == FETCH_WAIT);

endmodule

/* verilog/rvmini_execute.sv */
/*
  Single-cycle execute for LUI, ADDI, ADD and BNE with a 32 x 32 register file.
  Everything else retires as illegal with no write and a next PC of pc + 4.
  Retirement outputs and next_pc_o are combinational from instr_valid_i.
*/
`timescale 1ns/1ps

module rvmini_execute import rvmini_pkg::*; (
  input  logic                  clk_i,
  input  logic                  arst_n_i,

  input  logic                  instr_valid_i,
  input  logic [XLEN-1:0]       instr_word_i,
  input  logic [XLEN-1:0]       instr_pc_i,

  output logic [XLEN-1:0]       next_pc_o,

  // Retirement report
  output logic                  retire_valid_o,
  output logic [XLEN-1:0]       retire_pc_o,
  output logic                  retire_illegal_o,
  output logic                  retire_we_o,
  output logic [REG_ADDR_W-1:0] retire_rd_o,
  output logic [XLEN-1:0]       retire_wdata_o
);

  logic [XLEN-1:0]       rf_q [32];

  logic [6:0]            opcode;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  logic [REG_ADDR_W-1:0] rd;
  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;
  logic [XLEN-1:0]       rs1_val;
  logic [XLEN-1:0]       rs2_val;
  logic [XLEN-1:0]       imm_i;
  logic [XLEN-1:0]       imm_u;
  logic [XLEN-1:0]       imm_b;
  logic                  legal;
  logic                  writes_rd;
  logic                  branch_taken;
  logic [XLEN-1:0]       result;

  // Instruction fields
  assign opcode = instr_word_i[6:0];
  assign rd     = instr_word_i[11:7];
  assign funct3 = instr_word_i[14:12];
  assign rs1    = instr_word_i[19:15];
  assign rs2    = instr_word_i[24:20];
  assign funct7 = instr_word_i[31:25];

  assign imm_i = {{20{instr_word_i[31]}}, instr_word_i[31:20]};
  assign imm_u = {instr_word_i[31:12], 12'b0};
  assign imm_b = {{20{instr_word_i[31]}}, instr_word_i[7], instr_word_i[30:25],
                  instr_word_i[11:8], 1'b0};

  // x0 is hardwired to zero
  assign rs1_val = (rs1 == '0) ? '0 : rf_q[rs1];
  assign rs2_val = (rs2 == '0) ? '0 : rf_q[rs2];

  always_comb begin
    legal        = 1'b0;
    writes_rd    = 1'b0;
    branch_taken = 1'b0;
    result       = '0;
    case (opcode)
      OPC_LUI: begin
        legal     = 1'b1;
        writes_rd = 1'b1;
        result    = imm_u;
      end
      OPC_OP_IMM: begin
        if (funct3 == F3_ADD_ADDI) begin
          legal     = 1'b1;
          writes_rd = 1'b1;
          result    = rs1_val + imm_i;
        end
      end
      OPC_OP: begin
        if (funct3 == F3_ADD_ADDI && funct7 == F7_ADD) begin
          legal     = 1'b1;
          writes_rd = 1'b1;
          result    = rs1_val + rs2_val;
        end
      end
      OPC_BRANCH: begin
        if (funct3 == F3_BNE) begin
          legal        = 1'b1;
          branch_taken = (rs1_val != rs2_val);
        end
      end
      default: legal = 1'b0;
    endcase
  end

  assign next_pc_o = branch_taken ? (instr_pc_i + imm_b) : (instr_pc_i + XLEN'(4));

  assign retire_valid_o   = instr_valid_i;
  assign retire_pc_o      = instr_pc_i;
  assign retire_illegal_o = instr_valid_i && !legal;
  // Writes to x0 are dropped and reported as no write
  assign retire_we_o      = instr_valid_i && writes_rd && (rd != '0);
  assign retire_rd_o      = rd;
  assign retire_wdata_o   = result;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < 32; i++) begin
        rf_q[i] <= '0;
      end
    end else if (retire_we_o) begin
      rf_q[rd] <= result;
    end
  end

endmodule

/* verilog/rvmini_core.sv */
/*
  Core built from the fetch unit and the execute unit.
  Sleep is reported once fetch is disabled and no request is outstanding.
*/
`timescale 1ns/1ps

module rvmini_core import rvmini_pkg::*; (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  fetch_enable_i,

  // Instruction bus
  output logic                  instr_req_o,
  output logic [XLEN-1:0]       instr_addr_o,
  input  logic                  instr_gnt_i,
  input  logic                  instr_rvalid_i,
  input  logic [XLEN-1:0]       instr_rdata_i,

  // Retirement
  output logic                  retire_valid_o,
  output logic [XLEN-1:0]       retire_pc_o,
  output logic                  retire_illegal_o,
  output logic                  retire_we_o,
  output logic [REG_ADDR_W-1:0] retire_rd_o,
  output logic [XLEN-1:0]       retire_wdata_o,

  output logic                  core_sleep_o
);

  logic            instr_valid;
  logic [XLEN-1:0] instr_word;
  logic [XLEN-1:0] instr_pc;
  logic [XLEN-1:0] next_pc;
  logic            fetch_busy;

  rvmini_fetch fetch_i (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .fetch_enable_i ( fetch_enable_i ),
    .instr_req_o    ( instr_req_o    ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .next_pc_i      ( next_pc        ),
    .instr_valid_o  ( instr_valid    ),
    .instr_word_o   ( instr_word     ),
    .instr_pc_o     ( instr_pc       ),
    .busy_o         ( fetch_busy     )
  );

  rvmini_execute execute_i (
    .clk_i            ( clk_i            ),
    .arst_n_i         ( arst_n_i         ),
    .instr_valid_i    ( instr_valid      ),
    .instr_word_i     ( instr_word       ),
    .instr_pc_i       ( instr_pc         ),
    .next_pc_o        ( next_pc          ),
    .retire_valid_o   ( retire_valid_o   ),
    .retire_pc_o      ( retire_pc_o      ),
    .retire_illegal_o ( retire_illegal_o ),
    .retire_we_o      ( retire_we_o      ),
    .retire_rd_o      ( retire_rd_o      ),
    .retire_wdata_o   ( retire_wdata_o   )
  );

  assign core_sleep_o = !fetch_enable_i && !fetch_busy;

endmodule

/* verilog/rvmini_retire_log.sv */
/*
  Retirement statistics. Counters saturate at all ones.
  Values update on the edge that ends the retire cycle.
*/
`timescale 1ns/1ps

module rvmini_retire_log import rvmini_pkg::*; (
  input  logic             clk_i,
  input  logic             arst_n_i,

  input  logic             retire_valid_i,
  input  logic             retire_illegal_i,
  input  logic [XLEN-1:0]  retire_pc_i,

  output logic [CNT_W-1:0] instret_o,
  output logic [CNT_W-1:0] illegal_cnt_o,
  output logic [XLEN-1:0]  last_pc_o
);

  logic [CNT_W-1:0] instret_q;
  logic [CNT_W-1:0] illegal_cnt_q;
  logic [XLEN-1:0]  last_pc_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      instret_q     <= '0;
      illegal_cnt_q <= '0;
      last_pc_q     <= '0;
    end else if (retire_valid_i) begin
      last_pc_q <= retire_pc_i;
      if (instret_q != '1) begin
        instret_q <= instret_q + 1'b1;
      end
      // Illegal words still retire, so they count in both
      if (retire_illegal_i && illegal_cnt_q != '1) begin
        illegal_cnt_q <= illegal_cnt_q + 1'b1;
      end
    end
  end

  assign instret_o     = instret_q;
  assign illegal_cnt_o = illegal_cnt_q;
  assign last_pc_o     = last_pc_q;

endmodule

/* verilog/rvmini_wrapper.sv */
/*
  Top level with the core and the retirement logger watching the same retire port.
  Retirement outputs follow instr_rvalid_i in the same cycle; counters lag one cycle.
*/
`timescale 1ns/1ps

module rvmini_wrapper import rvmini_pkg::*; (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  fetch_enable_i,

  // Instruction bus
  output logic                  instr_req_o,
  output logic [XLEN-1:0]       instr_addr_o,
  input  logic                  instr_gnt_i,
  input  logic                  instr_rvalid_i,
  input  logic [XLEN-1:0]       instr_rdata_i,

  // Retirement
  output logic                  retire_valid_o,
  output logic [XLEN-1:0]       retire_pc_o,
  output logic                  retire_illegal_o,
  output logic                  retire_we_o,
  output logic [REG_ADDR_W-1:0] retire_rd_o,
  output logic [XLEN-1:0]       retire_wdata_o,

  // Statistics
  output logic [CNT_W-1:0]      instret_o,
  output logic [CNT_W-1:0]      illegal_cnt_o,
  output logic [XLEN-1:0]       last_pc_o,

  output logic                  core_sleep_o
);

  rvmini_core core_i (
    .clk_i            ( clk_i            ),
    .arst_n_i         ( arst_n_i         ),
    .fetch_enable_i   ( fetch_enable_i   ),
    .instr_req_o      ( instr_req_o      ),
    .instr_addr_o     ( instr_addr_o     ),
    .instr_gnt_i      ( instr_gnt_i      ),
    .instr_rvalid_i   ( instr_rvalid_i   ),
    .instr_rdata_i    ( instr_rdata_i    ),
    .retire_valid_o   ( retire_valid_o   ),
    .retire_pc_o      ( retire_pc_o      ),
    .retire_illegal_o ( retire_illegal_o ),
    .retire_we_o      ( retire_we_o      ),
    .retire_rd_o      ( retire_rd_o      ),
    .retire_wdata_o   ( retire_wdata_o   ),
    .core_sleep_o     ( core_sleep_o     )
  );

  rvmini_retire_log retire_log_i (
    .clk_i            ( clk_i            ),
    .arst_n_i         ( arst_n_i         ),
    .retire_valid_i   ( retire_valid_o   ),
    .retire_illegal_i ( retire_illegal_o ),
    .retire_pc_i      ( retire_pc_o      ),
    .instret_o        ( instret_o        ),
    .illegal_cnt_o    ( illegal_cnt_o    ),
    .last_pc_o        ( last_pc_o        )
  );

endmodule

/* testbench/tb_rvmini_wrapper.sv */
/*
  Directed tests for the RV32 subset wrapper.
  The memory model grants after 0..3 cycles and answers 1..3 cycles after accept.
  Each program is followed by a NOP pad that the fetch after the last retire reads.
  Instruction memory holds 256 words, so addresses alias above 1 KiB.
*/
`timescale 1ns/1ps

module tb_rvmini_wrapper import rvmini_pkg::*; ();

  // Instructions in all tests, pads included
  localparam int NUM_INSTR   = 45;
  localparam int WATCHDOG_NS = (NUM_INSTR * 10 + 16 + 50) * 4;

  logic                  clk;
  logic                  arst_n;
  logic                  fetch_enable;
  logic                  instr_req;
  logic [XLEN-1:0]       instr_addr;
  logic                  instr_gnt;
  logic                  instr_rvalid;
  logic [XLEN-1:0]       instr_rdata;
  logic                  retire_valid;
  logic [XLEN-1:0]       retire_pc;
  logic                  retire_illegal;
  logic                  retire_we;
  logic [REG_ADDR_W-1:0] retire_rd;
  logic [XLEN-1:0]       retire_wdata;
  logic [CNT_W-1:0]      instret;
  logic [CNT_W-1:0]      illegal_cnt;
  logic [XLEN-1:0]       last_pc;
  logic                  core_sleep;

  logic [XLEN-1:0]       imem [256];

  // Reference model state
  logic [XLEN-1:0]       ref_regs [32];
  logic [XLEN-1:0]       model_pc;
  logic [XLEN-1:0]       model_last_pc;
  logic [CNT_W-1:0]      model_count;
  logic [CNT_W-1:0]      model_illegal;
  logic [XLEN-1:0]       load_ptr;
  string                 test_name;

  // Register values as the DUT reported them on the retire port
  logic [XLEN-1:0]       dut_regs [32];

  rvmini_wrapper UUT (
    .clk_i            ( clk            ),
    .arst_n_i         ( arst_n         ),
    .fetch_enable_i   ( fetch_enable   ),
    .instr_req_o      ( instr_req      ),
    .instr_addr_o     ( instr_addr     ),
    .instr_gnt_i      ( instr_gnt      ),
    .instr_rvalid_i   ( instr_rvalid   ),
    .instr_rdata_i    ( instr_rdata    ),
    .retire_valid_o   ( retire_valid   ),
    .retire_pc_o      ( retire_pc      ),
    .retire_illegal_o ( retire_illegal ),
    .retire_we_o      ( retire_we      ),
    .retire_rd_o      ( retire_rd      ),
    .retire_wdata_o   ( retire_wdata   ),
    .instret_o        ( instret        ),
    .illegal_cnt_o    ( illegal_cnt    ),
    .last_pc_o        ( last_pc        ),
    .core_sleep_o     ( core_sleep     )
  );

  always #2 clk = ~clk;

  task automatic stop_with_failure();
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_word(input string what, input logic [XLEN-1:0] exp,
                            input logic [XLEN-1:0] act);
    if (act !== exp) begin
      $display("Fail %s: %s expected %h actual %h", test_name, what, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_reg_addr(input string what, input logic [REG_ADDR_W-1:0] exp,
                                input logic [REG_ADDR_W-1:0] act);
    if (act !== exp) begin
      $display("Fail %s: %s expected %0d actual %0d", test_name, what, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_count(input string what, input logic [CNT_W-1:0] exp,
                             input logic [CNT_W-1:0] act);
    if (act !== exp) begin
      $display("Fail %s: %s expected %0d actual %0d", test_name, what, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Fail %s: %s expected %b actual %b", test_name, what, exp, act);
      stop_with_failure();
    end
  endtask

  // RV32I encoders
  function automatic logic [XLEN-1:0] lui_word(input logic [REG_ADDR_W-1:0] rd,
                                               input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic logic [XLEN-1:0] addi_word(input logic [REG_ADDR_W-1:0] rd,
                                                input logic [REG_ADDR_W-1:0] rs1,
                                                input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic logic [XLEN-1:0] add_word(input logic [REG_ADDR_W-1:0] rd,
                                               input logic [REG_ADDR_W-1:0] rs1,
                                               input logic [REG_ADDR_W-1:0] rs2);
    return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
  endfunction

  function automatic logic [XLEN-1:0] bne_word(input logic [REG_ADDR_W-1:0] rs1,
                                               input logic [REG_ADDR_W-1:0] rs2,
                                               input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, 3'b001, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [7:0] word_index(input logic [XLEN-1:0] addr);
    return addr[9:2];
  endfunction

  task automatic put_instr(input logic [XLEN-1:0] word);
    imem[word_index(load_ptr)] = word;
    load_ptr = load_ptr + 32'd4;
  endtask

  // Steps the ISA model for one retirement and compares the retire port
  task automatic step_model();
    logic [XLEN-1:0]       word;
    logic [XLEN-1:0]       a;
    logic [XLEN-1:0]       b;
    logic [XLEN-1:0]       wdata;
    logic [XLEN-1:0]       npc;
    logic [REG_ADDR_W-1:0] rd;
    logic                  ill;
    logic                  wr;
    word  = imem[word_index(model_pc)];
    rd    = word[11:7];
    a     = ref_regs[word[19:15]];
    b     = ref_regs[word[24:20]];
    ill   = 1'b1;
    wr    = 1'b0;
    wdata = '0;
    npc   = model_pc + 32'd4;
    if (word[6:0] == 7'b0110111) begin
      ill   = 1'b0;
      wr    = 1'b1;
      wdata = {word[31:12], 12'h000};
    end else if (word[6:0] == 7'b0010011 && word[14:12] == 3'b000) begin
      ill   = 1'b0;
      wr    = 1'b1;
      wdata = a + {{20{word[31]}}, word[31:20]};
    end else if (word[6:0] == 7'b0110011 && word[14:12] == 3'b000 &&
                 word[31:25] == 7'b0000000) begin
      ill   = 1'b0;
      wr    = 1'b1;
      wdata = a + b;
    end else if (word[6:0] == 7'b1100011 && word[14:12] == 3'b001) begin
      ill = 1'b0;
      if (a != b) begin
        npc = model_pc + {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
      end
    end
    // x0 is never written
    if (rd == '0) begin
      wr = 1'b0;
    end
    check_word("retire pc", model_pc, retire_pc);
    check_bit("retire illegal", ill, retire_illegal);
    check_bit("retire write enable", wr, retire_we);
    if (wr) begin
      check_reg_addr("retire rd", rd, retire_rd);
      check_word("retire wdata", wdata, retire_wdata);
      ref_regs[rd] = wdata;
    end
    model_count   = model_count + 32'd1;
    model_illegal = model_illegal + (ill ? 32'd1 : 32'd0);
    model_last_pc = model_pc;
    model_pc      = npc;
  endtask

  task automatic serve_request();
    logic [XLEN-1:0] addr;
    int unsigned     gnt_wait;
    int unsigned     rsp_wait;
    addr     = instr_addr;
    gnt_wait = $urandom_range(0, 3);
    rsp_wait = $urandom_range(1, 3);
    repeat (gnt_wait) begin
      @(posedge clk);
      #1;
      check_bit("request held before grant", 1'b1, instr_req);
      check_word("address held before grant", addr, instr_addr);
    end
    instr_gnt = 1'b1;
    @(posedge clk);
    #1;
    instr_gnt = 1'b0;
    repeat (rsp_wait - 1) begin
      @(posedge clk);
      #1;
      check_bit("no second request while outstanding", 1'b0, instr_req);
    end
    instr_rvalid = 1'b1;
    instr_rdata  = imem[word_index(addr)];
    @(posedge clk);
    #1;
    instr_rvalid = 1'b0;
    instr_rdata  = '0;
  endtask

  initial begin : memory_model
    void'($urandom(32'h9031));
    wait (arst_n);
    forever begin
      if (instr_req) begin
        serve_request();
      end else begin
        @(posedge clk);
        #1;
      end
    end
  end

  initial begin : retire_monitor
    wait (arst_n);
    forever begin
      @(negedge clk);
      if (retire_valid) begin
        step_model();
        if (retire_we) begin
          dut_regs[retire_rd] = retire_wdata;
        end
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    stop_with_failure();
  end

  task automatic wait_sleep();
    @(negedge clk);
    while (!core_sleep) begin
      @(negedge clk);
    end
  endtask

  task automatic compare_stats();
    check_count("instret", model_count, instret);
    check_count("illegal count", model_illegal, illegal_cnt);
    check_word("last pc", model_last_pc, last_pc);
  endtask

  // Runs until the model reaches end_pc, then stops fetch after the pad
  task automatic run_until(input logic [XLEN-1:0] end_pc);
    @(posedge clk);
    #1;
    fetch_enable = 1'b1;
    wait (model_pc == end_pc);
    @(posedge clk);
    #1;
    fetch_enable = 1'b0;
    wait_sleep();
    compare_stats();
  endtask

  task automatic inspect_reset_state();
    test_name = "reset_state";
    @(negedge clk);
    check_bit("instr_req", 1'b0, instr_req);
    check_bit("retire_valid", 1'b0, retire_valid);
    check_count("instret", 32'd0, instret);
    check_count("illegal count", 32'd0, illegal_cnt);
    check_word("fetch address", BOOT_ADDR, instr_addr);
    check_bit("core_sleep", 1'b1, core_sleep);
  endtask

  task automatic straight_line_program();
    logic [XLEN-1:0] end_pc;
    test_name = "straight_line";
    load_ptr  = model_pc;
    put_instr(lui_word(5'd1, 20'h12345));
    put_instr(addi_word(5'd2, 5'd1, 12'h678));
    put_instr(addi_word(5'd3, 5'd0, 12'hfff));
    put_instr(add_word(5'd4, 5'd2, 5'd3));
    put_instr(add_word(5'd0, 5'd2, 5'd2));
    put_instr(addi_word(5'd8, 5'd0, 12'h005));
    put_instr(addi_word(5'd5, 5'd0, 12'h7ff));
    put_instr(add_word(5'd6, 5'd5, 5'd4));
    put_instr(lui_word(5'd7, 20'hfffff));
    end_pc = load_ptr;
    put_instr(addi_word(5'd0, 5'd0, 12'h000));
    run_until(end_pc);
  endtask

  task automatic branch_loop_program();
    logic [XLEN-1:0] end_pc;
    test_name = "branch_loop";
    load_ptr  = model_pc;
    put_instr(addi_word(5'd9, 5'd0, 12'h000));
    put_instr(addi_word(5'd10, 5'd0, 12'h005));
    // Five passes adding 3 each
    put_instr(addi_word(5'd9, 5'd9, 12'h003));
    put_instr(addi_word(5'd10, 5'd10, 12'hfff));
    put_instr(bne_word(5'd10, 5'd0, 13'h1ff8));
    // The operands are equal so this branch falls through
    put_instr(bne_word(5'd9, 5'd9, 13'h0008));
    put_instr(add_word(5'd11, 5'd9, 5'd0));
    end_pc = load_ptr;
    put_instr(addi_word(5'd0, 5'd0, 12'h000));
    run_until(end_pc);
    check_word("loop result x11", 32'd15, dut_regs[11]);
  endtask

  task automatic illegal_word_program();
    logic [XLEN-1:0] end_pc;
    test_name = "illegal";
    load_ptr  = model_pc;
    put_instr(32'h0000_0000);
    put_instr(32'hffff_ffff);
    put_instr(add_word(5'd20, 5'd1, 5'd2) | 32'h4000_0000);
    put_instr(addi_word(5'd21, 5'd1, 12'h001) | 32'h0000_2000);
    put_instr(bne_word(5'd1, 5'd2, 13'h0008) ^ 32'h0000_1000);
    put_instr(addi_word(5'd12, 5'd1, 12'h000));
    // x31 must still be zero after the all-ones word
    put_instr(add_word(5'd13, 5'd31, 5'd0));
    end_pc = load_ptr;
    put_instr(addi_word(5'd0, 5'd0, 12'h000));
    run_until(end_pc);
    check_count("illegal total", 32'd5, illegal_cnt);
  endtask

  task automatic fetch_enable_pause();
    logic [XLEN-1:0]  end_pc;
    logic [CNT_W-1:0] base;
    test_name = "fetch_enable";
    load_ptr  = model_pc;
    put_instr(addi_word(5'd14, 5'd0, 12'h001));
    repeat (5) begin
      put_instr(addi_word(5'd14, 5'd14, 12'h001));
    end
    end_pc = load_ptr;
    put_instr(addi_word(5'd0, 5'd0, 12'h000));
    base = model_count;
    @(posedge clk);
    #1;
    fetch_enable = 1'b1;
    wait (model_count == base + 32'd2);
    @(posedge clk);
    #1;
    fetch_enable = 1'b0;
    wait_sleep();
    compare_stats();
    repeat (50) begin
      @(negedge clk);
      check_bit("instr_req while disabled", 1'b0, instr_req);
      check_bit("retire_valid while disabled", 1'b0, retire_valid);
      check_bit("core_sleep while disabled", 1'b1, core_sleep);
    end
    check_word("resume address", model_pc, instr_addr);
    run_until(end_pc);
    check_word("final x14", 32'd6, dut_regs[14]);
  endtask

  initial begin : main
    clk           = 1'b0;
    arst_n        = 1'b0;
    fetch_enable  = 1'b0;
    instr_gnt     = 1'b0;
    instr_rvalid  = 1'b0;
    instr_rdata   = '0;
    model_pc      = BOOT_ADDR;
    model_last_pc = '0;
    model_count   = '0;
    model_illegal = '0;
    load_ptr      = BOOT_ADDR;
    test_name     = "setup";
    // A zero opcode field makes unused words decode as illegal
    for (int i = 0; i < 256; i++) begin
      imem[i] = {i[24:0], 7'b0000000};
    end
    for (int i = 0; i < 32; i++) begin
      ref_regs[i] = '0;
      dut_regs[i] = '0;
    end
    repeat (16) @(posedge clk);
    #1;
    arst_n = 1'b1;
    inspect_reset_state();
    straight_line_program();
    branch_loop_program();
    illegal_word_program();
    fetch_enable_pause();
    $display("PASS: all tests");
    $finish;
  end

endmodule

/* project.f */
verilog/rvmini_pkg.sv
verilog/rvmini_fetch.sv
verilog/rvmini_execute.sv
verilog/rvmini_core.sv
verilog/rvmini_retire_log.sv
verilog/rvmini_wrapper.sv
testbench/tb_rvmini_wrapper.sv

/* Makefile */
SRCS := $(wildcard verilog/*.sv testbench/*.sv)

obj_dir/Vtb_rvmini_wrapper: project.f $(SRCS)
	verilator --binary -j 0 -Wno-fatal --top-module tb_rvmini_wrapper \
		-f project.f -o Vtb_rvmini_wrapper

run: obj_dir/Vtb_rvmini_wrapper
	./obj_dir/Vtb_rvmini_wrapper

clean:
	rm -rf obj_dir

.PHONY: run clean
